// File: vlog.f
+incdir+source
source/jump_pkg.sv
source/jump_reserv_station.sv
source/jump_target_calc.sv
source/jump_unit.sv
test/jump_unit_asserts.sv
test/jump_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= jump_unit_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= === PASS ===
VFLAGS    ?= --assert --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q -F -- "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/jump_unit_tb.sv
`timescale 1ns/100ps
`include "jump_cfg.svh"

module jump_unit_tb;
  import jump_pkg::*;

  localparam int NUM_TAGS = 1 << `JUMP_TAG_W;
  localparam int ENTRIES = `JUMP_RS_ENTRIES;
  localparam int WAIT_LIMIT = 100;

  logic  clk;
  logic  rst;
  logic  disp_valid;
  tag_t  disp_dest;
  word_t disp_base;
  tag_t  disp_base_tag;
  word_t disp_imm;
  word_t disp_pc;
  logic  credit_return;
  logic  cdb_valid;
  tag_t  cdb_tag;
  word_t cdb_value;
  logic  res_valid;
  tag_t  res_tag;
  word_t res_next_pc;
  word_t res_link;

  integer seed;
  int     credits;
  int     returned;
  int     cycle;
  int     outstanding;
  int     test_errors;
  int     total_errors;
  int     tests_run;
  int     tests_failed;
  bit     check_latency;
  string  test_name;

  // reference copy of each outstanding jump, indexed by its rob tag
  bit    exp_pending [NUM_TAGS];
  tag_t  exp_src     [NUM_TAGS];
  word_t exp_base    [NUM_TAGS];
  word_t exp_imm     [NUM_TAGS];
  word_t exp_pc      [NUM_TAGS];
  int    disp_cycle  [NUM_TAGS];
  tag_t  wake_order  [$];
  tag_t  done_order  [$];

  jump_unit dut0 (
    .clk           (clk),
    .rst           (rst),
    .disp_valid    (disp_valid),
    .disp_dest     (disp_dest),
    .disp_base     (disp_base),
    .disp_base_tag (disp_base_tag),
    .disp_imm      (disp_imm),
    .disp_pc       (disp_pc),
    .credit_return (credit_return),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .cdb_value     (cdb_value),
    .res_valid     (res_valid),
    .res_tag       (res_tag),
    .res_next_pc   (res_next_pc),
    .res_link      (res_link)
  );

  bind jump_unit jump_unit_asserts asserts0 (
    .clk           (clk),
    .rst           (rst),
    .disp_valid    (disp_valid),
    .credit_return (credit_return),
    .iss_valid     (iss_valid),
    .res_valid     (res_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic value_mismatch(input string what, input word_t expected, input word_t actual);
    $display("FAIL %s: %s expected %h actual %h", test_name, what, expected, actual);
    test_errors++;
  endtask

  task automatic flag_error(input string what);
    $display("ERROR in %s: %s", test_name, what);
    test_errors++;
  endtask

  task automatic abort_run(input string why);
    $display("ERROR in %s: %s", test_name, why);
    $display("=== FAIL ===");
    $finish;
  endtask

  task automatic clear_table();
    for (int i = 0; i < NUM_TAGS; i++) begin
      exp_pending[i] = 1'b0;
    end
    wake_order.delete();
    done_order.delete();
    outstanding = 0;
    returned    = 0;
  endtask

  task automatic check_result();
    tag_t  t;
    word_t exp_next;
    word_t exp_link;
    t = res_tag;
    if (!exp_pending[t]) begin
      flag_error($sformatf("result for tag %0d that is not outstanding", t));
    end else begin
      assert (exp_src[t] == TAG_NONE)
        else flag_error($sformatf("tag %0d completed before its operand arrived", t));
      exp_next    = exp_pc[t] + exp_base[t] + exp_imm[t];
      exp_next[0] = 1'b0;  // jump targets are halfword aligned
      exp_link    = exp_pc[t] + word_t'(4);
      assert (res_next_pc == exp_next) else value_mismatch("next_pc", exp_next, res_next_pc);
      assert (res_link == exp_link) else value_mismatch("link", exp_link, res_link);
      if (check_latency) begin
        assert (cycle - disp_cycle[t] == 3)
          else value_mismatch("latency", 3, word_t'(cycle - disp_cycle[t]));
      end
      exp_pending[t] = 1'b0;
      outstanding--;
      done_order.push_back(t);
    end
  endtask

  // applies this cycle's drive at the next rising edge, then samples at the falling edge
  task automatic step();
    if (disp_valid) begin
      assert (credits > 0) else flag_error("dispatch driven with no credit left");
      credits--;
      exp_pending[disp_dest] = 1'b1;
      exp_src[disp_dest]     = disp_base_tag;
      exp_base[disp_dest]    = disp_base;
      exp_imm[disp_dest]     = disp_imm;
      exp_pc[disp_dest]      = disp_pc;
      disp_cycle[disp_dest]  = cycle;
      outstanding++;
    end
    if (cdb_valid) begin
      for (int i = 0; i < NUM_TAGS; i++) begin
        if (exp_pending[i] && exp_src[i] != TAG_NONE && exp_src[i] == cdb_tag) begin
          exp_base[i] = cdb_value;
          exp_src[i]  = TAG_NONE;
          wake_order.push_back(tag_t'(i));
        end
      end
    end
    @(negedge clk);
    cycle++;
    disp_valid = 1'b0;
    cdb_valid  = 1'b0;
    if (credit_return) begin
      credits++;
      returned++;
      assert (credits <= ENTRIES) else value_mismatch("credits", ENTRIES, word_t'(credits));
    end
    if (res_valid) begin
      check_result();
    end
  endtask

  task automatic dispatch(input tag_t dest, input tag_t src, input word_t base);
    int waited;
    waited = 0;
    while (credits == 0 && waited < WAIT_LIMIT) begin
      step();
      waited++;
    end
    if (credits == 0) begin
      abort_run("timed out waiting for a dispatch credit");
    end else begin
      disp_valid    = 1'b1;
      disp_dest     = dest;
      disp_base     = base;
      disp_base_tag = src;
      disp_imm      = $random(seed);
      disp_pc       = $random(seed);
      disp_pc[1:0]  = 2'b00;
    end
  endtask

  task automatic broadcast(input tag_t tag, input word_t value);
    cdb_valid = 1'b1;
    cdb_tag   = tag;
    cdb_value = value;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (outstanding != 0 && waited < WAIT_LIMIT) begin
      step();
      waited++;
    end
    if (outstanding != 0) begin
      abort_run("timed out waiting for outstanding results");
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    clear_table();
  endtask

  task automatic finish_test();
    repeat (2) step();  // a stray late result would show up here
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d check(s) failed", test_name, test_errors);
      tests_failed++;
    end
  endtask

  initial begin
    seed          = 38146;
    rst           = 1'b1;
    disp_valid    = 1'b0;
    disp_dest     = '0;
    disp_base     = '0;
    disp_base_tag = '0;
    disp_imm      = '0;
    disp_pc       = '0;
    cdb_valid     = 1'b0;
    cdb_tag       = '0;
    cdb_value     = '0;
    credits       = ENTRIES;
    cycle         = 0;
    total_errors  = 0;
    tests_run     = 0;
    tests_failed  = 0;
    check_latency = 1'b0;
    test_name     = "startup";
    clear_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    begin_test("ready_dispatch");
    check_latency = 1'b1;
    for (int k = 1; k <= 3; k++) begin
      dispatch(tag_t'(k), TAG_NONE, $random(seed));
      step();
    end
    drain();
    check_latency = 1'b0;
    finish_test();

    begin_test("wakeup");
    dispatch(tag_t'(4), tag_t'(12), $random(seed));
    step();
    repeat (6) step();
    broadcast(tag_t'(13), $random(seed));  // unrelated producer
    step();
    repeat (4) step();
    assert (outstanding == 1) else value_mismatch("waiting ops", 1, word_t'(outstanding));
    broadcast(tag_t'(12), $random(seed));
    step();
    drain();
    finish_test();

    begin_test("bypass");
    dispatch(tag_t'(5), tag_t'(14), $random(seed));
    broadcast(tag_t'(14), $random(seed));
    step();
    drain();
    finish_test();

    begin_test("credits_full");
    for (int k = 0; k < ENTRIES; k++) begin
      dispatch(tag_t'(6 + k), tag_t'(12 + k), $random(seed));
      step();
    end
    assert (credits == 0) else value_mismatch("credits when full", 0, word_t'(credits));
    repeat (5) step();
    assert (returned == 0) else value_mismatch("credits returned", 0, word_t'(returned));
    for (int k = 0; k < ENTRIES; k++) begin
      broadcast(tag_t'(12 + k), $random(seed));
      step();
    end
    drain();
    assert (credits == ENTRIES) else value_mismatch("credits", ENTRIES, word_t'(credits));
    assert (returned == ENTRIES) else value_mismatch("returned", ENTRIES, word_t'(returned));
    finish_test();

    begin_test("out_of_order");
    for (int k = 0; k < ENTRIES; k++) begin
      dispatch(tag_t'(7 + k), tag_t'(12 + k), $random(seed));
      step();
    end
    for (int k = ENTRIES - 1; k >= 0; k--) begin
      broadcast(tag_t'(12 + k), $random(seed));
      step();
      step();
    end
    drain();
    assert (done_order.size() == ENTRIES)
      else value_mismatch("completions", ENTRIES, word_t'(done_order.size()));
    for (int i = 0; i < done_order.size() && i < wake_order.size(); i++) begin
      assert (done_order[i] == wake_order[i])
        else value_mismatch("completion order", word_t'(wake_order[i]), word_t'(done_order[i]));
      assert (done_order[i] == tag_t'(7 + ENTRIES - 1 - i))
        else value_mismatch("completion tag", word_t'(7 + ENTRIES - 1 - i),
                            word_t'(done_order[i]));
    end
    finish_test();

    begin_test("reset");
    dispatch(tag_t'(11), tag_t'(12), $random(seed));
    step();
    rst = 1'b1;
    repeat (5) step();
    rst = 1'b0;
    clear_table();  // the waiting op is gone, so any result for it is an error
    credits = ENTRIES;
    broadcast(tag_t'(12), $random(seed));
    step();
    repeat (6) step();
    dispatch(tag_t'(1), TAG_NONE, $random(seed));
    step();
    drain();
    finish_test();

    $display("tests run %0d, tests failed %0d, checks failed %0d, assertion failures %0d",
             tests_run, tests_failed, total_errors, dut0.asserts0.failures);
    if (total_errors == 0 && dut0.asserts0.failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: test/jump_unit_asserts.sv
`timescale 1ns/100ps
`include "jump_cfg.svh"

module jump_unit_asserts (
  input logic clk,
  input logic rst,
  input logic disp_valid,
  input logic credit_return,
  input logic iss_valid,
  input logic res_valid
);
  localparam logic [`JUMP_CREDIT_W-1:0] FULL_CREDITS = `JUMP_CREDIT_W'(`JUMP_RS_ENTRIES);

  logic [`JUMP_CREDIT_W-1:0] credits;  // credits the dispatcher holds
  int unsigned               failures = 0;  // number of failed properties

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= FULL_CREDITS;
    end else begin
      credits <= credits - `JUMP_CREDIT_W'(disp_valid) + `JUMP_CREDIT_W'(credit_return);
    end
  end

  credit_bound: assert property (@(posedge clk) disable iff (rst) credits <= FULL_CREDITS)
    else begin
      failures++;
      $error("dispatcher credit count is above the station size");
    end

  // a pulse seen in this cycle may be spent at this edge
  disp_needs_credit: assert property (@(posedge clk) disable iff (rst)
    disp_valid |-> (credits != '0) || credit_return)
    else begin
      failures++;
      $error("dispatch while the dispatcher held no credit");
    end

  reset_clears: assert property (@(posedge clk) rst |=> !res_valid && !iss_valid && !credit_return)
    else begin
      failures++;
      $error("valid or credit output high after reset");
    end

endmodule

// File: source/jump_unit.sv
`timescale 1ns/100ps

module jump_unit (
  input  logic            clk,
  input  logic            rst,
  input  logic            disp_valid,
  input  jump_pkg::tag_t  disp_dest,
  input  jump_pkg::word_t disp_base,
  input  jump_pkg::tag_t  disp_base_tag,
  input  jump_pkg::word_t disp_imm,
  input  jump_pkg::word_t disp_pc,
  output logic            credit_return,
  input  logic            cdb_valid,
  input  jump_pkg::tag_t  cdb_tag,
  input  jump_pkg::word_t cdb_value,
  output logic            res_valid,
  output jump_pkg::tag_t  res_tag,
  output jump_pkg::word_t res_next_pc,
  output jump_pkg::word_t res_link
);
  import jump_pkg::*;

  logic  iss_valid;
  tag_t  iss_dest;
  word_t iss_base;
  word_t iss_imm;
  word_t iss_pc;

  jump_reserv_station rs0 (
    .clk           (clk),
    .rst           (rst),
    .disp_valid    (disp_valid),
    .disp_dest     (disp_dest),
    .disp_base     (disp_base),
    .disp_base_tag (disp_base_tag),
    .disp_imm      (disp_imm),
    .disp_pc       (disp_pc),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .cdb_value     (cdb_value),
    .credit_return (credit_return),
    .iss_valid     (iss_valid),
    .iss_dest      (iss_dest),
    .iss_base      (iss_base),
    .iss_imm       (iss_imm),
    .iss_pc        (iss_pc)
  );

  jump_target_calc calc0 (
    .clk         (clk),
    .rst         (rst),
    .iss_valid   (iss_valid),
    .iss_dest    (iss_dest),
    .iss_base    (iss_base),
    .iss_imm     (iss_imm),
    .iss_pc      (iss_pc),
    .res_valid   (res_valid),
    .res_tag     (res_tag),
    .res_next_pc (res_next_pc),
    .res_link    (res_link)
  );

endmodule

// File: source/jump_target_calc.sv
`timescale 1ns/100ps

module jump_target_calc (
  input  logic            clk,
  input  logic            rst,
  input  logic            iss_valid,
  input  jump_pkg::tag_t  iss_dest,
  input  jump_pkg::word_t iss_base,
  input  jump_pkg::word_t iss_imm,
  input  jump_pkg::word_t iss_pc,
  output logic            res_valid,
  output jump_pkg::tag_t  res_tag,
  output jump_pkg::word_t res_next_pc,
  output jump_pkg::word_t res_link
);
  import jump_pkg::*;

  localparam word_t LINK_OFFSET = word_t'(4);

  word_t target_addr;
  word_t link_addr;

  always_comb begin
    target_addr = jump_target(iss_pc, iss_base, iss_imm);
    link_addr   = iss_pc + LINK_OFFSET;  // return address of the jump
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= iss_valid;
    end
  end

  // result payload only loads with a valid issue
  always_ff @(posedge clk) begin
    if (iss_valid) begin
      res_tag     <= iss_dest;
      res_next_pc <= target_addr;
      res_link    <= link_addr;
    end
  end

endmodule

// File: source/jump_reserv_station.sv
`timescale 1ns/100ps
`include "jump_cfg.svh"

module jump_reserv_station (
  input  logic            clk,
  input  logic            rst,
  input  logic            disp_valid,
  input  jump_pkg::tag_t  disp_dest,
  input  jump_pkg::word_t disp_base,
  input  jump_pkg::tag_t  disp_base_tag,
  input  jump_pkg::word_t disp_imm,
  input  jump_pkg::word_t disp_pc,
  input  logic            cdb_valid,
  input  jump_pkg::tag_t  cdb_tag,
  input  jump_pkg::word_t cdb_value,
  output logic            credit_return,
  output logic            iss_valid,
  output jump_pkg::tag_t  iss_dest,
  output jump_pkg::word_t iss_base,
  output jump_pkg::word_t iss_imm,
  output jump_pkg::word_t iss_pc
);
  import jump_pkg::*;

  localparam int unsigned NUM_ENTRIES = `JUMP_RS_ENTRIES;
  localparam int unsigned IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

  jump_entry_t                entries [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0]     entry_free;
  logic [NUM_ENTRIES-1:0]     entry_ready;
  logic [NUM_ENTRIES-1:0]     entry_wake;
  logic                       free_found;
  logic [IDX_W-1:0]           free_idx;
  logic                       sel_found;
  logic [IDX_W-1:0]           sel_idx;
  logic                       disp_bypass;
  logic                       disp_write;
  jump_entry_t                disp_entry;

  // priority encoder, the lowest set bit wins
  function automatic logic [IDX_W-1:0] lowest_index(input logic [NUM_ENTRIES-1:0] vec);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = IDX_W'(i);
      end
    end
    return idx;
  endfunction

  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      entry_free[i]  = !entries[i].valid;
      entry_ready[i] = entries[i].valid && (entries[i].base_tag == TAG_NONE);
      entry_wake[i]  = entries[i].valid && cdb_valid &&
                       (entries[i].base_tag != TAG_NONE) &&
                       (entries[i].base_tag == cdb_tag);  // snoop the cdb for a pending base
    end
  end

  always_comb begin
    free_found = |entry_free;
    free_idx   = lowest_index(entry_free);
    sel_found  = |entry_ready;
    sel_idx    = lowest_index(entry_ready);
  end

  // the operand may be broadcast in the very cycle it is dispatched
  always_comb begin
    disp_bypass = cdb_valid && (disp_base_tag != TAG_NONE) && (disp_base_tag == cdb_tag);
    disp_write  = disp_valid && free_found;  // credits keep a free slot available

    disp_entry.valid    = 1'b1;
    disp_entry.dest     = disp_dest;
    disp_entry.base     = disp_bypass ? cdb_value : disp_base;
    disp_entry.base_tag = disp_bypass ? TAG_NONE : disp_base_tag;
    disp_entry.imm      = disp_imm;
    disp_entry.pc       = disp_pc;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (entry_wake[i]) begin
          entries[i].base     <= cdb_value;
          entries[i].base_tag <= TAG_NONE;
        end
      end

      if (sel_found) begin
        entries[sel_idx].valid <= 1'b0;  // slot frees as the op moves to the issue register
      end

      if (disp_write) begin
        entries[free_idx] <= disp_entry;  // never the slot being issued, that one is valid
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      iss_valid     <= 1'b0;
      credit_return <= 1'b0;
    end else begin
      iss_valid     <= sel_found;
      credit_return <= sel_found;  // one credit per freed slot
    end
  end

  always_ff @(posedge clk) begin
    if (sel_found) begin
      iss_dest <= entries[sel_idx].dest;
      iss_base <= entries[sel_idx].base;
      iss_imm  <= entries[sel_idx].imm;
      iss_pc   <= entries[sel_idx].pc;
    end
  end

endmodule

// File: source/jump_pkg.sv
`include "jump_cfg.svh"

package jump_pkg;

  typedef logic [`JUMP_XLEN-1:0] word_t;

  typedef logic [`JUMP_TAG_W-1:0] tag_t;

  // marks an operand whose value is already present
  localparam tag_t TAG_NONE = '0;

  // one reservation station slot
  typedef struct packed {
    logic  valid;
    tag_t  dest;      // rob tag of this jump
    word_t base;      // base operand value once known
    tag_t  base_tag;  // producer tag of base, TAG_NONE when base is valid
    word_t imm;
    word_t pc;
  } jump_entry_t;

  // target address with bit 0 forced low
  function automatic word_t jump_target(input word_t pc, input word_t base, input word_t imm);
    word_t sum;
    sum = pc + base + imm;
    return sum & ~word_t'(1);
  endfunction

endpackage

// File: source/jump_cfg.svh
`ifndef JUMP_CFG_SVH
`define JUMP_CFG_SVH

// data path and pc width
`define JUMP_XLEN 32

// rob tag width, tag 0 is reserved for a ready operand
`define JUMP_TAG_W 4

// slots in the jump reservation station
`define JUMP_RS_ENTRIES 4

// credit counter width, must hold JUMP_RS_ENTRIES
`define JUMP_CREDIT_W 3

`endif
